//--- project.f
+incdir+.
conv_pkg.sv
win_ctrl_if.sv
pixel_counter.sv
frame_fsm.sv
line_buffer.sv
window_shift.sv
conv_window_top.sv
tb_conv_window.sv

//--- run_sim.sh
#!/bin/sh
# build and run the window former testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_conv_window -o sim_conv

output=$(./obj_dir/sim_conv)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

//--- tb_conv_window.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module tb_conv_window;

	localparam int KL            = `KERNEL_LEN;
	localparam int WIN_W         = KL * KL * `PIX_W;
	localparam int PLANE_W       = KL * KL * `CH_W;
	localparam int PIX_PER_FRAME = `IMG_W * `IMG_H;
	localparam int WIN_PER_FRAME = ((`IMG_H - KL) / `STRIDE + 1) * ((`IMG_W - KL) / `STRIDE + 1);
	localparam int MAX_GAP       = 3;                // worst-case idle cycles between pixels
	localparam int NUM_FRAMES    = 7;                // full frames plus the two partial ones
	localparam int DRAIN_LIMIT   = 16;
	localparam int CYCLE_LIMIT   = NUM_FRAMES * PIX_PER_FRAME * (MAX_GAP + 1) + 400;

	logic                 i_sclk;
	logic                 i_arst_n;
	logic                 i_vsync;
	logic                 i_valid;
	logic [`PIX_W-1:0]    i_tdata;
	logic                 o_vsync;
	logic                 o_hsync;
	logic                 o_valid;
	logic [WIN_W-1:0]     o_tdata;

	int                   cyc;                       // posedges since time 0
	int                   recv_cnt;                  // o_valid beats seen
	int                   err_data;
	int                   err_flag;
	int                   err_time;
	int                   err_count;
	int                   err_other;
	logic [31:0]          seed_ret;

	// reference model state
	logic [`PIX_W-1:0]    frame_mem [`IMG_H][`IMG_W];
	int                   m_col;
	int                   m_row;
	int                   m_win_row;                 // row of the last modelled window or -1
	logic                 m_active;                  // between vsync and the last pixel
	logic [WIN_W-1:0]     exp_data [$];
	logic                 exp_hs [$];
	logic                 exp_vs [$];
	int                   exp_due [$];
	logic [WIN_W-1:0]     e_data;
	logic                 e_hs;
	logic                 e_vs;
	int                   e_due;

	conv_window_top dut_i
	(
		.i_sclk   (i_sclk),
		.i_arst_n (i_arst_n),
		.i_vsync  (i_vsync),
		.i_valid  (i_valid),
		.i_tdata  (i_tdata),
		.o_vsync  (o_vsync),
		.o_hsync  (o_hsync),
		.o_valid  (o_valid),
		.o_tdata  (o_tdata)
	);

	initial
		i_sclk = 1'b0;
	always #2 i_sclk = ~i_sclk;                      // 4 ns period

	// index sits where a window's bottom-right corner may land
	function automatic logic on_grid(input int idx);
		return (idx >= KL - 1) && (((idx - (KL - 1)) % `STRIDE) == 0);
	endfunction

	// three row-major planes with the first element on top
	function automatic logic [WIN_W-1:0] build_window(input int r, input int c);
		logic [PLANE_W-1:0] pr;
		logic [PLANE_W-1:0] pg;
		logic [PLANE_W-1:0] pb;
		logic [`PIX_W-1:0]  pix;
		pr = '0;
		pg = '0;
		pb = '0;
		for (int rr = 0; rr < KL; rr++)
		begin
			for (int cc = 0; cc < KL; cc++)
			begin
				pix = frame_mem[r - KL + 1 + rr][c - KL + 1 + cc];
				pr  = (pr << `CH_W) | PLANE_W'(pix[3*`CH_W-1 -: `CH_W]);
				pg  = (pg << `CH_W) | PLANE_W'(pix[2*`CH_W-1 -: `CH_W]);
				pb  = (pb << `CH_W) | PLANE_W'(pix[`CH_W-1:0]);
			end
		end
		return {pr, pg, pb};
	endfunction

	always @(posedge i_sclk)
	begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT)
		begin
			$display("timeout, run went past %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	// outputs checked and pixels modelled mid-cycle
	always @(negedge i_sclk)
	begin
		if (!i_arst_n)
		begin
			if (o_valid || o_hsync || o_vsync)
			begin
				err_other++;
				$display("outputs not low while reset is held, cycle %0d", cyc);
			end
			exp_data.delete();                           // in-flight windows are lost
			exp_hs.delete();
			exp_vs.delete();
			exp_due.delete();
			m_active = 1'b0;
		end
		else
		begin
			if (o_valid)
			begin
				recv_cnt++;
				if (exp_data.size() == 0)
				begin
					err_other++;
					$display("o_valid high with no window expected, cycle %0d", cyc);
				end
				else
				begin
					e_data = exp_data.pop_front();
					e_hs   = exp_hs.pop_front();
					e_vs   = exp_vs.pop_front();
					e_due  = exp_due.pop_front();
					if (o_tdata !== e_data)
					begin
						err_data++;
						$display("mismatch window_data exp %h got %h", e_data, o_tdata);
					end
					if (o_hsync !== e_hs)
					begin
						err_flag++;
						$display("mismatch hsync exp %b got %b", e_hs, o_hsync);
					end
					if (o_vsync !== e_vs)
					begin
						err_flag++;
						$display("mismatch vsync exp %b got %b", e_vs, o_vsync);
					end
					if (cyc != e_due)
					begin
						err_time++;
						$display("mismatch latency exp %0d got %0d", e_due, cyc);
					end
				end
			end
			else
			begin
				if (o_hsync || o_vsync)
				begin
					err_other++;
					$display("sync flag high without o_valid, cycle %0d", cyc);
				end
				if (exp_due.size() > 0 && exp_due[0] <= cyc)
				begin
					err_time++;
					$display("expected window did not appear by cycle %0d", cyc);
					void'(exp_data.pop_front());
					void'(exp_hs.pop_front());
					void'(exp_vs.pop_front());
					void'(exp_due.pop_front());
				end
			end

			if (i_vsync)                                 // restart drops the partial frame
			begin
				m_col     = 0;
				m_row     = 0;
				m_win_row = -1;
				m_active  = 1'b1;
			end
			else if (i_valid && m_active)
			begin
				frame_mem[m_row][m_col] = i_tdata;
				if (on_grid(m_row) && on_grid(m_col))
				begin
					exp_data.push_back(build_window(m_row, m_col));
					exp_hs.push_back(m_row != m_win_row);   // first window in this row
					exp_vs.push_back(m_win_row < 0);        // first window since vsync
					exp_due.push_back(cyc + 2);
					m_win_row = m_row;
				end
				if (m_col == `IMG_W - 1)
				begin
					m_col = 0;
					if (m_row == `IMG_H - 1)
						m_active = 1'b0;                 // ignored until the next vsync
					else
						m_row++;
				end
				else
					m_col++;
			end
		end
	end

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge i_sclk);
			i_valid <= 1'b0;
			i_vsync <= 1'b0;
		end
	endtask

	task automatic send_vsync();
		@(posedge i_sclk);
		i_valid <= 1'b0;
		i_vsync <= 1'b1;                             // cleared by the next drive
	endtask

	task automatic drive_pixel(input logic [`PIX_W-1:0] pix);
		@(posedge i_sclk);
		i_vsync <= 1'b0;
		i_valid <= 1'b1;
		i_tdata <= pix;
	endtask

	task automatic send_pixels(input int n, input int max_gap);
		int          gap;
		logic [31:0] rnd;
		for (int i = 0; i < n; i++)
		begin
			gap = $urandom_range(max_gap, 0);
			if (gap > 0)
				idle(gap);
			rnd = $urandom;
			drive_pixel(rnd[`PIX_W-1:0]);
		end
		idle(1);
	endtask

	task automatic apply_reset(input int n);
		@(posedge i_sclk);
		i_arst_n <= 1'b0;
		i_valid  <= 1'b0;
		i_vsync  <= 1'b0;
		repeat (n) @(posedge i_sclk);
		i_arst_n <= 1'b1;
	endtask

	// one whole frame and the wait for its windows
	task automatic run_frame(input int max_gap);
		int base;
		int wait_cyc;
		base = recv_cnt;
		send_vsync();
		send_pixels(PIX_PER_FRAME, max_gap);
		wait_cyc = 0;
		while ((recv_cnt - base) < WIN_PER_FRAME && wait_cyc < DRAIN_LIMIT)
		begin
			@(posedge i_sclk);
			wait_cyc++;
		end
		idle(3);                                     // room for a stray extra window
		if ((recv_cnt - base) != WIN_PER_FRAME)
		begin
			err_count++;
			$display("mismatch window_count exp %0d got %0d", WIN_PER_FRAME, recv_cnt - base);
		end
	endtask

	initial
	begin
		i_arst_n  = 1'b0;
		i_vsync   = 1'b0;
		i_valid   = 1'b0;
		i_tdata   = '0;
		cyc       = 0;
		recv_cnt  = 0;
		err_data  = 0;
		err_flag  = 0;
		err_time  = 0;
		err_count = 0;
		err_other = 0;
		m_col     = 0;
		m_row     = 0;
		m_win_row = -1;
		m_active  = 1'b0;
		seed_ret  = $urandom(51756);
		repeat (8) @(posedge i_sclk);
		i_arst_n <= 1'b1;

		run_frame(0);                                // back-to-back pixels
		run_frame(MAX_GAP);
		run_frame(MAX_GAP);

		send_vsync();                                // reset lands mid-frame
		send_pixels(100, MAX_GAP);
		apply_reset(8);
		idle(2);
		run_frame(MAX_GAP);

		send_vsync();                                // new vsync abandons this one
		send_pixels(70, MAX_GAP);
		idle(4);
		run_frame(MAX_GAP);

		idle(8);
		if (exp_data.size() != 0)
		begin
			err_count++;
			$display("%0d expected windows never came out", exp_data.size());
		end

		$display("errors data=%0d flags=%0d latency=%0d count=%0d other=%0d",
			err_data, err_flag, err_time, err_count, err_other);
		if (err_data + err_flag + err_time + err_count + err_other == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- conv_window_top.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_window_top
(
	input  logic                                          i_sclk,
	input  logic                                          i_arst_n,
	input  logic                                          i_vsync,
	input  logic                                          i_valid,
	input  logic [`PIX_W-1:0]                             i_tdata,
	output logic                                          o_vsync,
	output logic                                          o_hsync,
	output logic                                          o_valid,
	output logic [`KERNEL_LEN*`KERNEL_LEN*`PIX_W-1:0]     o_tdata
);

	conv_pkg::col_t     col;                         // current pixel position
	conv_pkg::row_t     row;
	logic               col_on_grid;
	logic               row_on_grid;
	logic               last_pix;
	conv_pkg::column_t  column;                      // registered vertical slice

	win_ctrl_if ctrl_if ();

	pixel_counter pixel_counter_i
	(
		.i_sclk        (i_sclk),
		.i_arst_n      (i_arst_n),
		.i_vsync       (i_vsync),
		.i_valid       (i_valid),
		.o_col         (col),
		.o_row         (row),
		.o_col_on_grid (col_on_grid),
		.o_row_on_grid (row_on_grid),
		.o_last_pix    (last_pix)
	);

	frame_fsm frame_fsm_i
	(
		.i_sclk        (i_sclk),
		.i_arst_n      (i_arst_n),
		.i_vsync       (i_vsync),
		.i_valid       (i_valid),
		.i_col         (col),
		.i_row         (row),
		.i_col_on_grid (col_on_grid),
		.i_row_on_grid (row_on_grid),
		.i_last_pix    (last_pix),
		.ctrl          (ctrl_if.ctrl)
	);

	line_buffer line_buffer_i
	(
		.i_sclk        (i_sclk),
		.i_arst_n      (i_arst_n),
		.i_tdata       (i_tdata),                    // raw word into the pixel union
		.ctrl          (ctrl_if.data),
		.o_column      (column)
	);

	window_shift window_shift_i
	(
		.i_sclk        (i_sclk),
		.i_arst_n      (i_arst_n),
		.i_column      (column),
		.ctrl          (ctrl_if.data),
		.o_valid       (o_valid),
		.o_hsync       (o_hsync),
		.o_vsync       (o_vsync),
		.o_tdata       (o_tdata)
	);

endmodule

//--- window_shift.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module window_shift
(
	input  logic                                          i_sclk,
	input  logic                                          i_arst_n,
	input  conv_pkg::column_t                             i_column,
	win_ctrl_if.data                                      ctrl,
	output logic                                          o_valid,
	output logic                                          o_hsync,
	output logic                                          o_vsync,
	output logic [`KERNEL_LEN*`KERNEL_LEN*`PIX_W-1:0]     o_tdata
);

	localparam int NE = `KERNEL_LEN * `KERNEL_LEN;   // elements per plane

	logic                   pix_we_d;                // strobes aligned to i_column
	logic                   emit_d;
	logic                   row_first_d;
	logic                   frame_first_d;
	conv_pkg::column_t      col_q [`KERNEL_LEN-1];   // older columns, [0] leftmost
	conv_pkg::column_t      win_col [`KERNEL_LEN];   // full window, newest on the right
	logic [NE*`CH_W-1:0]    plane_r;
	logic [NE*`CH_W-1:0]    plane_g;
	logic [NE*`CH_W-1:0]    plane_b;

	always_ff @(posedge i_sclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			pix_we_d      <= 1'b0;
			emit_d        <= 1'b0;
			row_first_d   <= 1'b0;
			frame_first_d <= 1'b0;
		end
		else
		begin
			pix_we_d      <= ctrl.pix_we;                // column leaves line buffer one cycle later
			emit_d        <= ctrl.emit;
			row_first_d   <= ctrl.row_first;
			frame_first_d <= ctrl.frame_first;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (pix_we_d)
		begin
			for (int c = 0; c < `KERNEL_LEN - 2; c++)
				col_q[c] <= col_q[c+1];                  // shift left
			col_q[`KERNEL_LEN-2] <= i_column;
		end
	end

	always_comb
	begin
		for (int c = 0; c < `KERNEL_LEN - 1; c++)
			win_col[c] = col_q[c];
		win_col[`KERNEL_LEN-1] = i_column;             // live column closes the window
	end

	// row-major per plane, top-left in the msbs
	always_comb
	begin
		for (int r = 0; r < `KERNEL_LEN; r++)
		begin
			for (int c = 0; c < `KERNEL_LEN; c++)
			begin
				plane_r[(NE-1-(r*`KERNEL_LEN+c))*`CH_W +: `CH_W] = win_col[c][r].ch.red;
				plane_g[(NE-1-(r*`KERNEL_LEN+c))*`CH_W +: `CH_W] = win_col[c][r].ch.green;
				plane_b[(NE-1-(r*`KERNEL_LEN+c))*`CH_W +: `CH_W] = win_col[c][r].ch.blue;
			end
		end
	end

	always_ff @(posedge i_sclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= 1'b0;
			o_hsync <= 1'b0;
			o_vsync <= 1'b0;
		end
		else
		begin
			o_valid <= emit_d;
			o_hsync <= row_first_d;                      // fsm only flags with emit
			o_vsync <= frame_first_d;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (emit_d)
			o_tdata <= {plane_r, plane_g, plane_b};      // red on top, blue at the bottom
	end

	a_sync_with_valid: assert property (@(posedge i_sclk) disable iff (!i_arst_n)
		(o_hsync || o_vsync) |-> o_valid);
	a_vsync_is_row_start: assert property (@(posedge i_sclk) disable iff (!i_arst_n)
		o_vsync |-> o_hsync);                            // frame start is also a row start

endmodule

//--- line_buffer.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module line_buffer
(
	input  logic               i_sclk,
	input  logic               i_arst_n,
	input  conv_pkg::pixel_u   i_tdata,
	win_ctrl_if.data           ctrl,
	output conv_pkg::column_t  o_column
);

	// mem[0] holds the oldest row, mem[KERNEL_LEN-2] the row just above
	logic [`PIX_W-1:0] mem [`KERNEL_LEN-1][`IMG_W];

	// each row ages by one memory at the same column
	always_ff @(posedge i_sclk)
	begin
		if (ctrl.pix_we)
		begin
			for (int j = 0; j < `KERNEL_LEN - 2; j++)
				mem[j][ctrl.wr_col] <= mem[j+1][ctrl.wr_col];   // read before overwrite
			mem[`KERNEL_LEN-2][ctrl.wr_col] <= i_tdata.word;   // newest row
		end
	end

	// vertical column, bottom entry is the live pixel
	always_ff @(posedge i_sclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_column <= '0;
		else if (ctrl.pix_we)
		begin
			for (int j = 0; j < `KERNEL_LEN - 1; j++)
				o_column[j].word <= mem[j][ctrl.wr_col];        // older rows, same column
			o_column[`KERNEL_LEN-1] <= i_tdata;
		end
	end

endmodule

//--- frame_fsm.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module frame_fsm
(
	input  logic            i_sclk,
	input  logic            i_arst_n,
	input  logic            i_vsync,
	input  logic            i_valid,
	input  conv_pkg::col_t  i_col,
	input  conv_pkg::row_t  i_row,
	input  logic            i_col_on_grid,
	input  logic            i_row_on_grid,
	input  logic            i_last_pix,
	win_ctrl_if.ctrl        ctrl
);

	localparam logic [1:0] S_IDLE = 2'd0;            // no frame seen yet
	localparam logic [1:0] S_FILL = 2'd1;            // rows above the first window row
	localparam logic [1:0] S_RUN  = 2'd2;            // windows may complete
	localparam logic [1:0] S_DONE = 2'd3;            // frame finished until the next vsync

	logic [1:0] state;
	logic       first_pend;                          // no window emitted since vsync
	logic       fill_end;

	// last pixel of the row just above the first window row
	assign fill_end = i_valid && (i_col == conv_pkg::col_t'(`IMG_W - 1)) &&
		(i_row == conv_pkg::row_t'(`KERNEL_LEN - 2));

	always_ff @(posedge i_sclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state      <= S_IDLE;
			first_pend <= 1'b0;
		end
		else if (i_vsync)                                // restart from any state
		begin
			state      <= S_FILL;
			first_pend <= 1'b1;
		end
		else
		begin
			if (ctrl.emit)
				first_pend <= 1'b0;
			case (state)
				S_FILL:
					if (fill_end)
						state <= S_RUN;
				S_RUN:
					if (i_valid && i_last_pix)
						state <= S_DONE;
				default:
					state <= state;                      // idle and done hold
			endcase
		end
	end

	assign ctrl.pix_we      = i_valid;                 // every pixel goes to the line memories
	assign ctrl.wr_col      = i_col;
	assign ctrl.emit        = (state == S_RUN) && i_valid && i_col_on_grid && i_row_on_grid;
	assign ctrl.row_first   = ctrl.emit && (i_col == conv_pkg::col_t'(`KERNEL_LEN - 1));
	assign ctrl.frame_first = ctrl.emit && first_pend;

	// every window corner of a frame arrives while running
	a_grid_in_run: assert property (@(posedge i_sclk) disable iff (!i_arst_n)
		(i_valid && i_col_on_grid && i_row_on_grid && (state != S_IDLE)) |->
		(state == S_RUN));

endmodule

//--- pixel_counter.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module pixel_counter
(
	input  logic            i_sclk,
	input  logic            i_arst_n,
	input  logic            i_vsync,
	input  logic            i_valid,
	output conv_pkg::col_t  o_col,
	output conv_pkg::row_t  o_row,
	output logic            o_col_on_grid,
	output logic            o_row_on_grid,
	output logic            o_last_pix
);

	localparam int PH_W = $clog2(`STRIDE + 1);     // stride phase width, at least 1 bit

	logic [PH_W-1:0] col_ph;                         // offset from KERNEL_LEN-1, mod stride
	logic [PH_W-1:0] row_ph;
	logic            col_last;
	logic            row_last;

	assign col_last = (o_col == conv_pkg::col_t'(`IMG_W - 1));
	assign row_last = (o_row == conv_pkg::row_t'(`IMG_H - 1));

	always_ff @(posedge i_sclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_col  <= '0;
			o_row  <= '0;
			col_ph <= '0;
			row_ph <= '0;
		end
		else if (i_vsync)                                // new frame, drop whatever was in flight
		begin
			o_col  <= '0;
			o_row  <= '0;
			col_ph <= '0;
			row_ph <= '0;
		end
		else if (i_valid)
		begin
			if (col_last)                                // row wrap
			begin
				o_col  <= '0;
				col_ph <= '0;
				o_row  <= row_last ? '0 : o_row + 1'b1;
				if (row_last)
					row_ph <= '0;
				else if (o_row >= conv_pkg::row_t'(`KERNEL_LEN - 1))   // phase runs once on grid
					row_ph <= (row_ph == PH_W'(`STRIDE - 1)) ? '0 : row_ph + 1'b1;
			end
			else
			begin
				o_col <= o_col + 1'b1;
				if (o_col >= conv_pkg::col_t'(`KERNEL_LEN - 1))
					col_ph <= (col_ph == PH_W'(`STRIDE - 1)) ? '0 : col_ph + 1'b1;
			end
		end
	end

	// bottom-right of a full window lands on the stride grid
	assign o_col_on_grid = (o_col >= conv_pkg::col_t'(`KERNEL_LEN - 1)) && (col_ph == '0);
	assign o_row_on_grid = (o_row >= conv_pkg::row_t'(`KERNEL_LEN - 1)) && (row_ph == '0);
	assign o_last_pix    = col_last && row_last;

	a_count_range: assert property (@(posedge i_sclk) disable iff (!i_arst_n)
		(o_col < `IMG_W) && (o_row < `IMG_H));       // counts stay inside the frame

endmodule

//--- win_ctrl_if.sv
`timescale 1ns/1ps

// window strobes, all qualified by the accepted pixel cycle
interface win_ctrl_if;

	logic             pix_we;           // pixel accepted this cycle
	conv_pkg::col_t   wr_col;           // its column
	logic             emit;             // pixel closes a window on the grid
	logic             row_first;        // first window of a window row
	logic             frame_first;      // first window since vsync

	modport ctrl
	(
		output pix_we,
		output wr_col,
		output emit,
		output row_first,
		output frame_first
	);

	modport data
	(
		input  pix_we,
		input  wr_col,
		input  emit,
		input  row_first,
		input  frame_first
	);

endinterface

//--- conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

	// one rgb word, moved whole or split per colour
	typedef union packed
	{
		logic [`PIX_W-1:0] word;            // raw 24-bit view for the line memories
		struct packed
		{
			logic [`CH_W-1:0] red;          // top byte
			logic [`CH_W-1:0] green;
			logic [`CH_W-1:0] blue;         // low byte
		} ch;
	} pixel_u;

	typedef logic [$clog2(`IMG_W)-1:0] col_t;   // column index
	typedef logic [$clog2(`IMG_H)-1:0] row_t;   // row index

	// vertical slice of the window, [0] is the oldest row
	typedef pixel_u [`KERNEL_LEN-1:0] column_t;

endpackage

//--- conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// image geometry, one frame in raster order
`define IMG_W       16                  // pixels per row
`define IMG_H       12                  // rows per frame

// window shape on the stride grid
`define KERNEL_LEN  3                   // window side
`define STRIDE      2                   // step in x and y

// pixel format, rgb888
`define CH_W        8                   // bits per colour
`define PIX_W       (3 * `CH_W)         // packed rgb word

`endif
